// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module coreTb -o coreSim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/coreSim > sim.log 2>&1; cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } \
    || { grep -q "PASS: all tests" sim.log && echo "simulation passed" || exit 1; }

// File: source/decodeStage.sv
module decodeStage (
    input  logic clk,
    input  logic rst,
    input  mipsIsa::wordT pcD,
    input  mipsIsa::wordT instrD,
    input  logic wbWe,
    input  logic [4:0] wbAddr,
    input  mipsIsa::wordT wbData,
    input  logic [1:0] fwdCmpA,
    input  logic [1:0] fwdCmpB,
    input  mipsIsa::wordT resultM,
    input  mipsIsa::wordT linkM,
    output pipeCtrl::decExStage decEx,
    output logic [1:0] tuseRs,
    output logic [1:0] tuseRt,
    output logic branchTaken,
    output logic jumpTaken,
    output mipsIsa::wordT targetPc
);
    mipsIsa::wordT regs [32];
    mipsIsa::wordT rsVal, rtVal, cmpA, cmpB, immSext;
    logic [5:0] op, fn;
    logic [4:0] rsAddr, rtAddr, rdAddr, writeAddr;
    logic regWrite;
    logic [1:0] tnew;

    assign op = instrD[mipsIsa::opHi:mipsIsa::opLo];
    assign fn = instrD[mipsIsa::fnHi:0];
    assign rsAddr = instrD[mipsIsa::rsHi:mipsIsa::rsLo];
    assign rtAddr = instrD[mipsIsa::rtHi:mipsIsa::rtLo];
    assign rdAddr = instrD[mipsIsa::rdHi:mipsIsa::rdLo];
    assign immSext = {{16{instrD[mipsIsa::immHi]}}, instrD[mipsIsa::immHi:0]};

    // r0 is cleared by reset and never written afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe && wbAddr != 5'd0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // write-first read, so W needs no path into D
    assign rsVal = (wbWe && wbAddr == rsAddr && rsAddr != 5'd0) ? wbData : regs[rsAddr];
    assign rtVal = (wbWe && wbAddr == rtAddr && rtAddr != 5'd0) ? wbData : regs[rtAddr];

    assign cmpA = fwdCmpA == pipeCtrl::cmpMLink ? linkM
                : fwdCmpA == pipeCtrl::cmpMResult ? resultM : rsVal;
    assign cmpB = fwdCmpB == pipeCtrl::cmpMLink ? linkM
                : fwdCmpB == pipeCtrl::cmpMResult ? resultM : rtVal;

    always_comb begin
        regWrite = 1'b0;
        writeAddr = 5'd0;
        tnew = pipeCtrl::tnewNone;
        tuseRs = pipeCtrl::tuseNone;
        tuseRt = pipeCtrl::tuseNone;
        case (op)
            mipsIsa::opSpecial: begin
                if (fn == mipsIsa::fnAddu || fn == mipsIsa::fnSubu) begin
                    regWrite = 1'b1;
                    writeAddr = rdAddr;
                    tnew = pipeCtrl::tnewAlu;
                    tuseRs = pipeCtrl::tuseAlu;
                    tuseRt = pipeCtrl::tuseAlu;
                end
            end
            mipsIsa::opOri, mipsIsa::opLui, mipsIsa::opLw: begin
                regWrite = 1'b1;
                writeAddr = rtAddr;
                tnew = (op == mipsIsa::opLw) ? pipeCtrl::tnewLoad : pipeCtrl::tnewAlu;
                // lui ignores rs
                tuseRs = (op == mipsIsa::opLui) ? pipeCtrl::tuseNone : pipeCtrl::tuseAlu;
            end
            mipsIsa::opSw: begin
                tuseRs = pipeCtrl::tuseAlu;
                tuseRt = pipeCtrl::tuseStore;
            end
            mipsIsa::opBeq: begin
                tuseRs = pipeCtrl::tuseCmp;
                tuseRt = pipeCtrl::tuseCmp;
            end
            mipsIsa::opJal: begin
                regWrite = 1'b1;
                writeAddr = mipsIsa::regRa;
                tnew = pipeCtrl::tnewAlu;
            end
            default: ;
        endcase
    end

    assign branchTaken = op == mipsIsa::opBeq && cmpA == cmpB;
    assign jumpTaken = op == mipsIsa::opJal;
    // branch offset is relative to the delay slot
    assign targetPc = jumpTaken ? {pcD[31:28], instrD[mipsIsa::targetHi:0], 2'b00}
                                : pcD + 32'd4 + {immSext[29:0], 2'b00};

    assign decEx = '{pc: pcD, instr: instrD, rsVal: rsVal, rtVal: rtVal, rsAddr: rsAddr,
                     rtAddr: rtAddr, writeAddr: writeAddr, regWrite: regWrite, tnew: tnew};
endmodule

// File: source/executeStage.sv
module executeStage (
    input  pipeCtrl::decExStage decEx,
    input  logic [1:0] fwdAluA,
    input  logic [1:0] fwdAluB,
    input  mipsIsa::wordT resultM,
    input  mipsIsa::wordT linkM,
    input  mipsIsa::wordT resultW,
    output pipeCtrl::exMemStage exMem
);
    mipsIsa::wordT srcA, srcB, aluResult;
    logic [15:0] imm;
    logic [5:0] op;
    logic [1:0] tnewNext;

    function automatic mipsIsa::wordT pickOperand(
        input logic [1:0] sel,
        input mipsIsa::wordT regVal,
        input mipsIsa::wordT resM,
        input mipsIsa::wordT lnkM,
        input mipsIsa::wordT resW
    );
        case (sel)
            pipeCtrl::aluMLink:   return lnkM;
            pipeCtrl::aluMResult: return resM;
            pipeCtrl::aluW:       return resW;
            default:              return regVal;
        endcase
    endfunction

    assign op = decEx.instr[mipsIsa::opHi:mipsIsa::opLo];
    assign imm = decEx.instr[mipsIsa::immHi:0];
    assign srcA = pickOperand(fwdAluA, decEx.rsVal, resultM, linkM, resultW);
    // srcB doubles as store data for sw
    assign srcB = pickOperand(fwdAluB, decEx.rtVal, resultM, linkM, resultW);

    always_comb begin
        case (op)
            mipsIsa::opSpecial: begin
                aluResult = (decEx.instr[mipsIsa::fnHi:0] == mipsIsa::fnSubu) ? srcA - srcB
                                                                               : srcA + srcB;
            end
            mipsIsa::opOri:               aluResult = srcA | {16'b0, imm};
            mipsIsa::opLui:               aluResult = {imm, 16'b0};
            mipsIsa::opLw, mipsIsa::opSw: aluResult = srcA + {{16{imm[15]}}, imm};
            mipsIsa::opJal:               aluResult = decEx.pc + 32'd8;
            default:                      aluResult = '0;
        endcase
    end

    assign tnewNext = (decEx.tnew == pipeCtrl::tnewNone) ? pipeCtrl::tnewNone : decEx.tnew - 2'd1;

    assign exMem = '{pc: decEx.pc, instr: decEx.instr, aluResult: aluResult, storeData: srcB,
                     rtAddr: decEx.rtAddr, writeAddr: decEx.writeAddr,
                     regWrite: decEx.regWrite, isLoad: op == mipsIsa::opLw, tnew: tnewNext};
endmodule

// File: source/fetchStage.sv
module fetchStage (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic branchTaken,
    input  logic jumpTaken,
    input  mipsIsa::wordT targetPc,
    input  logic progWe,
    input  logic [mipsIsa::imemAddrWidth-1:0] progAddr,
    input  mipsIsa::wordT progData,
    output mipsIsa::wordT pcF,
    output mipsIsa::wordT instrF
);
    mipsIsa::wordT imem [mipsIsa::imemDepth];

    // stall wins over a redirect, decode re-evaluates next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pcF <= '0;
        end else if (!stall) begin
            pcF <= (branchTaken || jumpTaken) ? targetPc : pcF + 32'd4;
        end
    end

    // program load only while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst && progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // word addressed, registered by the F/D stage
    assign instrF = imem[pcF[mipsIsa::imemAddrWidth+1:2]];
endmodule

// File: source/hazardUnit.sv
module hazardUnit (
    input  logic [4:0] readRsD,
    input  logic [4:0] readRtD,
    input  logic [4:0] readRsE,
    input  logic [4:0] readRtE,
    input  logic [4:0] readRtM,
    input  logic [4:0] writeAddrE,
    input  logic [4:0] writeAddrM,
    input  logic [4:0] writeAddrW,
    input  logic regWriteE,
    input  logic regWriteM,
    input  logic regWriteW,
    input  logic [1:0] tuseRs,
    input  logic [1:0] tuseRt,
    input  logic [1:0] tnewE,
    input  logic [1:0] tnewM,
    input  mipsIsa::wordT instrM,
    output logic [1:0] fwdCmpA,
    output logic [1:0] fwdCmpB,
    output logic [1:0] fwdAluA,
    output logic [1:0] fwdAluB,
    output logic fwdDm,
    output logic stallF,
    output logic stallD,
    output logic flushE
);
    logic linkHitM;
    logic loadM;
    logic stallRs;
    logic stallRt;

    function automatic logic hits(input logic [4:0] addr, input logic we, input logic [4:0] wa);
        return we && addr != 5'd0 && addr == wa;
    endfunction

    // jal sitting in M only has its link value ready
    assign linkHitM = regWriteM && writeAddrM == mipsIsa::regRa
                      && instrM[mipsIsa::opHi:mipsIsa::opLo] == mipsIsa::opJal;

    assign loadM = instrM[mipsIsa::opHi:mipsIsa::opLo] == mipsIsa::opLw;

    // W reaches the compare operands through the write-first register file
    assign fwdCmpA = !hits(readRsD, regWriteM, writeAddrM) ? pipeCtrl::cmpNone
                   : linkHitM ? pipeCtrl::cmpMLink : pipeCtrl::cmpMResult;
    assign fwdCmpB = !hits(readRtD, regWriteM, writeAddrM) ? pipeCtrl::cmpNone
                   : linkHitM ? pipeCtrl::cmpMLink : pipeCtrl::cmpMResult;

    // newest producer wins
    assign fwdAluA = hits(readRsE, regWriteM, writeAddrM)
                     ? (linkHitM ? pipeCtrl::aluMLink : pipeCtrl::aluMResult)
                   : hits(readRsE, regWriteW, writeAddrW) ? pipeCtrl::aluW : pipeCtrl::aluNone;
    assign fwdAluB = hits(readRtE, regWriteM, writeAddrM)
                     ? (linkHitM ? pipeCtrl::aluMLink : pipeCtrl::aluMResult)
                   : hits(readRtE, regWriteW, writeAddrW) ? pipeCtrl::aluW : pipeCtrl::aluNone;

    assign fwdDm = hits(readRtM, regWriteW, writeAddrW) ? pipeCtrl::dmW : pipeCtrl::dmNone;

    // stall while a producer will not be ready by the time D needs it
    assign stallRs = (hits(readRsD, regWriteE, writeAddrE) && tnewE > tuseRs)
                  || (hits(readRsD, regWriteM, writeAddrM) && tnewM > tuseRs);
    assign stallRt = (hits(readRtD, regWriteE, writeAddrE) && tnewE > tuseRt)
                  || (hits(readRtD, regWriteM, writeAddrM) && tnewM > tuseRt);

    assign stallF = stallRs || stallRt;
    assign stallD = stallRs || stallRt;
    assign flushE = stallRs || stallRt;

    always_comb begin
        // a beq reading a load in M is held until the load reaches W
        loadCmpHeld: assert final (
            stallD || !loadM
            || ((tuseRs != pipeCtrl::tuseCmp || fwdCmpA == pipeCtrl::cmpNone)
                && (tuseRt != pipeCtrl::tuseCmp || fwdCmpB == pipeCtrl::cmpNone)))
            else $error("hazardUnit: compare operand forwarded from a load in M");
    end
endmodule

// File: source/memoryStage.sv
module memoryStage (
    input  logic clk,
    input  pipeCtrl::exMemStage exMem,
    input  logic fwdDm,
    input  mipsIsa::wordT resultW,
    output pipeCtrl::memWbStage memWb
);
    mipsIsa::wordT dmem [mipsIsa::dmemDepth];
    mipsIsa::wordT storeData;
    logic [mipsIsa::dmemAddrWidth-1:0] wordAddr;

    assign wordAddr = exMem.aluResult[mipsIsa::dmemAddrWidth+1:2];

    // a load just ahead in W may own the store data
    assign storeData = (fwdDm == pipeCtrl::dmW) ? resultW : exMem.storeData;

    always_ff @(posedge clk) begin
        if (exMem.instr[mipsIsa::opHi:mipsIsa::opLo] == mipsIsa::opSw) begin
            dmem[wordAddr] <= storeData;
        end
    end

    assign memWb = '{pc: exMem.pc,
                     result: exMem.isLoad ? dmem[wordAddr] : exMem.aluResult,
                     writeAddr: exMem.writeAddr,
                     regWrite: exMem.regWrite};
endmodule

// File: source/mipsCore.sv
module mipsCore (
    input  logic clk,
    input  logic rst,
    input  logic progWe,
    input  logic [mipsIsa::imemAddrWidth-1:0] progAddr,
    input  mipsIsa::wordT progData,
    output logic wbValid,
    output logic [4:0] wbAddr,
    output mipsIsa::wordT wbData,
    output mipsIsa::wordT wbPc
);
    pipeCtrl::fetchDecStage fetchDecD, fetchDecQ;
    pipeCtrl::decExStage decExD, decExQ;
    pipeCtrl::exMemStage exMemD, exMemQ;
    pipeCtrl::memWbStage memWbD, memWbQ;
    mipsIsa::wordT pcF, instrF, targetPc, resultM, linkM, resultW;
    logic branchTaken, jumpTaken, stallF, stallD, flushE, fwdDm;
    logic [1:0] tuseRs, tuseRt, fwdCmpA, fwdCmpB, fwdAluA, fwdAluB;

    assign fetchDecD = '{pc: pcF, instr: instrF};
    assign resultM = exMemQ.aluResult;
    assign linkM = exMemQ.pc + 32'd8;
    assign resultW = memWbQ.result;

    fetchStage fetchUnit (.clk, .rst, .stall(stallF), .branchTaken, .jumpTaken, .targetPc,
                          .progWe, .progAddr, .progData, .pcF, .instrF);

    pipeStage #(.payloadT(pipeCtrl::fetchDecStage)) fdReg (
        .clk, .rst, .stall(stallD), .flush(1'b0), .d(fetchDecD), .q(fetchDecQ));

    decodeStage decodeUnit (.clk, .rst, .pcD(fetchDecQ.pc), .instrD(fetchDecQ.instr),
                            .wbWe(memWbQ.regWrite), .wbAddr(memWbQ.writeAddr),
                            .wbData(resultW), .fwdCmpA, .fwdCmpB, .resultM, .linkM,
                            .decEx(decExD), .tuseRs, .tuseRt, .branchTaken, .jumpTaken,
                            .targetPc);

    pipeStage #(.payloadT(pipeCtrl::decExStage)) deReg (
        .clk, .rst, .stall(1'b0), .flush(flushE), .d(decExD), .q(decExQ));

    executeStage executeUnit (.decEx(decExQ), .fwdAluA, .fwdAluB, .resultM, .linkM, .resultW,
                              .exMem(exMemD));

    pipeStage #(.payloadT(pipeCtrl::exMemStage)) emReg (
        .clk, .rst, .stall(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ));

    memoryStage memoryUnit (.clk, .exMem(exMemQ), .fwdDm, .resultW, .memWb(memWbD));

    pipeStage #(.payloadT(pipeCtrl::memWbStage)) mwReg (
        .clk, .rst, .stall(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ));

    hazardUnit hazards (
        .readRsD(fetchDecQ.instr[mipsIsa::rsHi:mipsIsa::rsLo]),
        .readRtD(fetchDecQ.instr[mipsIsa::rtHi:mipsIsa::rtLo]),
        .readRsE(decExQ.rsAddr), .readRtE(decExQ.rtAddr), .readRtM(exMemQ.rtAddr),
        .writeAddrE(decExQ.writeAddr), .writeAddrM(exMemQ.writeAddr),
        .writeAddrW(memWbQ.writeAddr), .regWriteE(decExQ.regWrite),
        .regWriteM(exMemQ.regWrite), .regWriteW(memWbQ.regWrite),
        .tuseRs, .tuseRt, .tnewE(decExQ.tnew), .tnewM(exMemQ.tnew), .instrM(exMemQ.instr),
        .fwdCmpA, .fwdCmpB, .fwdAluA, .fwdAluB, .fwdDm, .stallF, .stallD, .flushE);

    // retiring write stream, r0 writes are not reported
    assign wbValid = memWbQ.regWrite && memWbQ.writeAddr != 5'd0;
    assign wbAddr = memWbQ.writeAddr;
    assign wbData = resultW;
    assign wbPc = memWbQ.pc;
endmodule

// File: source/mipsIsa.sv
package mipsIsa;
    localparam int dataWidth = 32;
    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;
    localparam int imemAddrWidth = $clog2(imemDepth);
    localparam int dmemAddrWidth = $clog2(dmemDepth);

    typedef logic [dataWidth-1:0] wordT;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJal = 6'h03;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // function codes under opSpecial
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;

    localparam logic [4:0] regRa = 5'd31;

    // instruction field positions
    // fn, imm and target all start at bit 0
    localparam int opHi = 31;
    localparam int opLo = 26;
    localparam int rsHi = 25;
    localparam int rsLo = 21;
    localparam int rtHi = 20;
    localparam int rtLo = 16;
    localparam int rdHi = 15;
    localparam int rdLo = 11;
    localparam int fnHi = 5;
    localparam int immHi = 15;
    localparam int targetHi = 25;
endpackage

// File: source/pipeCtrl.sv
package pipeCtrl;
    // compare operand sources in decode
    localparam logic [1:0] cmpNone = 2'd0;
    localparam logic [1:0] cmpMResult = 2'd1;
    localparam logic [1:0] cmpMLink = 2'd2;

    // ALU operand sources in execute
    localparam logic [1:0] aluNone = 2'd0;
    localparam logic [1:0] aluW = 2'd1;
    localparam logic [1:0] aluMResult = 2'd2;
    localparam logic [1:0] aluMLink = 2'd3;

    // store data source in memory
    localparam logic dmNone = 1'b0;
    localparam logic dmW = 1'b1;

    // cycles after decode until an operand is consumed
    localparam logic [1:0] tuseCmp = 2'd0;
    localparam logic [1:0] tuseAlu = 2'd1;
    localparam logic [1:0] tuseStore = 2'd2;
    localparam logic [1:0] tuseNone = 2'd3;

    // cycles until a result can be forwarded, counts down per stage
    localparam logic [1:0] tnewNone = 2'd0;
    localparam logic [1:0] tnewAlu = 2'd1;
    localparam logic [1:0] tnewLoad = 2'd2;

    typedef struct packed {
        mipsIsa::wordT pc;
        mipsIsa::wordT instr;
    } fetchDecStage;

    typedef struct packed {
        mipsIsa::wordT pc;
        mipsIsa::wordT instr;
        mipsIsa::wordT rsVal;
        mipsIsa::wordT rtVal;
        logic [4:0] rsAddr;
        logic [4:0] rtAddr;
        logic [4:0] writeAddr;
        logic regWrite;
        logic [1:0] tnew;
    } decExStage;

    typedef struct packed {
        mipsIsa::wordT pc;
        mipsIsa::wordT instr;
        mipsIsa::wordT aluResult;
        mipsIsa::wordT storeData;
        logic [4:0] rtAddr;
        logic [4:0] writeAddr;
        logic regWrite;
        logic isLoad;
        logic [1:0] tnew;
    } exMemStage;

    typedef struct packed {
        mipsIsa::wordT pc;
        mipsIsa::wordT result;
        logic [4:0] writeAddr;
        logic regWrite;
    } memWbStage;
endpackage

// File: source/pipeStage.sv
module pipeStage #(
    parameter type payloadT = mipsIsa::wordT
) (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic flush,
    input  payloadT d,
    output payloadT q
);
    // an all-zero payload is a bubble with regWrite low
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    // F/D only stalls and D/E only flushes, so the two never meet
    stallFlushExclusive: assert property (@(posedge clk) disable iff (rst) !(stall && flush))
        else $error("pipeStage: stall and flush in the same cycle");
endmodule

// File: testbench/coreGolden.txt
# P <word index> <instruction>       program word, hex
# W <reg> <data> <pc>                expected retiring write, hex; T <name> tags a section
T aluChain
P 00 3c011234
P 01 34215678
P 02 34020005
P 03 00221821
P 04 00612023
P 05 00832821
W 01 12340000 00000000
W 01 12345678 00000004
W 02 00000005 00000008
W 03 1234567d 0000000c
W 04 00000005 00000010
W 05 12345682 00000014
T storeForward
P 06 ac050008
P 07 8c060008
W 06 12345682 0000001c
T loadUse
P 08 00c23821
P 09 ac02000c
P 0a 8c08000c
P 0b 11020002
P 0c 34090011
P 0d 34090099
W 07 12345687 00000020
W 08 00000005 00000028
W 09 00000011 00000030
T branchSlot
P 0e 340a0007
P 0f 11420003
P 10 01425821
P 11 340c0003
P 12 118c0002
P 13 340d0013
P 14 340d00ee
W 0a 00000007 00000038
W 0b 0000000c 00000040
W 0c 00000003 00000044
W 0d 00000013 0000004c
T jalLink
P 15 0c000018
P 16 03e07021
P 17 340f00ff
W 1f 0000005c 00000054
W 0e 0000005c 00000058
T zeroReg
P 18 34000055
P 19 00018021
P 1a 1000ffff
P 1b 00000000
W 10 12345678 00000064

// File: testbench/coreTb.sv
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int writeTimeout = 200;
    localparam int quietCycles = 60;
    localparam int resetCycles = 16;

    logic clk;
    logic rst;
    logic progWe;
    logic [mipsIsa::imemAddrWidth-1:0] progAddr;
    mipsIsa::wordT progData;
    logic wbValid;
    logic [4:0] wbAddr;
    mipsIsa::wordT wbData;
    mipsIsa::wordT wbPc;

    // program image and expected write stream from the golden file
    logic [31:0] progAddrQ [$];
    logic [31:0] progWordQ [$];
    logic [31:0] expAddrQ [$];
    logic [31:0] expDataQ [$];
    logic [31:0] expPcQ [$];
    string expNameQ [$];

    mipsCore u_mipsCore (
        .clk(clk),
        .rst(rst),
        .progWe(progWe),
        .progAddr(progAddr),
        .progData(progData),
        .wbValid(wbValid),
        .wbAddr(wbAddr),
        .wbData(wbData),
        .wbPc(wbPc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic stopWithFailure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic compareField(input string testName, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("CHECK FAILED %s: %s expected 0x%08h actual 0x%08h",
                     testName, field, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic readGolden();
        int fd;
        int n;
        string line;
        string curName;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        curName = "none";
        fd = $fopen("testbench/coreGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/coreGolden.txt");
            stopWithFailure();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0) begin
                // first character picks the record kind
                if (line.getc(0) == "T") begin
                    n = $sscanf(line, "T %s", curName);
                end else if (line.getc(0) == "P") begin
                    n = $sscanf(line, "P %h %h", a, b);
                    progAddrQ.push_back(a);
                    progWordQ.push_back(b);
                end else if (line.getc(0) == "W") begin
                    n = $sscanf(line, "W %h %h %h", a, b, c);
                    expAddrQ.push_back(a);
                    expDataQ.push_back(b);
                    expPcQ.push_back(c);
                    expNameQ.push_back(curName);
                end
            end
        end
        $fclose(fd);
    endtask

    // program words go in one per cycle while reset is high
    task automatic loadProgram();
        for (int i = 0; i < progAddrQ.size(); i++) begin
            @(negedge clk);
            progWe = 1'b1;
            progAddr = progAddrQ[i][mipsIsa::imemAddrWidth-1:0];
            progData = progWordQ[i];
        end
        @(negedge clk);
        progWe = 1'b0;
    endtask

    task automatic waitForWrite(input string testName);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wbValid && cycles < writeTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!wbValid) begin
            $display("no register write seen within %0d cycles in %s, core appears stuck",
                     writeTimeout, testName);
            stopWithFailure();
        end
    endtask

    initial begin
        rst = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;

        readGolden();
        if (expAddrQ.size() == 0) begin
            $display("golden file holds no expected writes");
            stopWithFailure();
        end
        loadProgram();
        // reset stays high a further 16 cycles after the load
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < expAddrQ.size(); i++) begin
            waitForWrite(expNameQ[i]);
            compareField(expNameQ[i], "wbAddr", expAddrQ[i], {27'd0, wbAddr});
            compareField(expNameQ[i], "wbData", expDataQ[i], wbData);
            compareField(expNameQ[i], "wbPc", expPcQ[i], wbPc);
        end

        // the core now spins on its self-loop and must stay silent
        for (int i = 0; i < quietCycles; i++) begin
            @(negedge clk);
            assert (!wbValid) else begin
                $display("unexpected register write to r%0d at pc 0x%08h after the last one",
                         wbAddr, wbPc);
                stopWithFailure();
            end
        end

        $display("PASS: all tests");
        $finish;
    end
endmodule

// File: verilog.f
source/mipsIsa.sv
source/pipeCtrl.sv
source/hazardUnit.sv
source/pipeStage.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/mipsCore.sv
testbench/coreTb.sv
